// File: Bender.yml
package:
  name: tft_touch

sources:
  - files:
      - rtl/touch_pkg.sv
      - rtl/tft_pkg.sv
      - rtl/touchpad_controller.sv
      - rtl/tft_timing.sv
      - rtl/cursor_overlay.sv
      - rtl/tft_touch_top.sv
  - target: test
    files:
      - verification/touch_panel_model.sv
      - verification/tb_tft_touch.sv

// File: files.f
rtl/touch_pkg.sv
rtl/tft_pkg.sv
rtl/touchpad_controller.sv
rtl/tft_timing.sv
rtl/cursor_overlay.sv
rtl/tft_touch_top.sv
verification/touch_panel_model.sv
verification/tb_tft_touch.sv

// File: rtl/cursor_overlay.sv
`timescale 1ns/1ns

module cursor_overlay import touch_pkg::*, tft_pkg::*; #(
    parameter int X_OFFSET        = 150,
    parameter int Y_OFFSET        = 300,
    parameter int PRESS_THRESHOLD = 256,
    parameter int SCALE_SHIFT     = 3
) (
    input  logic         cclk,
    input  logic         rst_n,
    input  touch_point_t point,
    input  logic         point_valid,
    input  pixel_pos_t   pos,
    input  logic         active,
    input  logic         pix_stb,
    input  logic         new_frame,
    input  rgb_t         background,
    output rgb_t         rgb,
    output logic         data_ena
);

    touch_point_t           held;
    logic                   held_ok;
    logic                   pressed;
    logic                   take_lock;
    logic [RESULT_BITS-1:0] map_x;
    logic [RESULT_BITS-1:0] map_y;
    logic [RESULT_BITS-1:0] lock_x;
    logic [RESULT_BITS-1:0] lock_y;
    logic [RESULT_BITS-1:0] cur_x;
    logic [RESULT_BITS-1:0] cur_y;
    logic                   on_cross;

    assign pressed   = held_ok && (held.z >= RESULT_BITS'(PRESS_THRESHOLD));
    assign take_lock = new_frame && pressed;

    // offset subtraction wraps in 12 bits before the scale shift
    assign map_x = (held.x - RESULT_BITS'(X_OFFSET)) >> SCALE_SHIFT;
    assign map_y = (held.y - RESULT_BITS'(Y_OFFSET)) >> SCALE_SHIFT;

    // a new lock already covers pixel (0,0) of its frame
    assign cur_x = take_lock ? map_x : lock_x;
    assign cur_y = take_lock ? map_y : lock_y;

    assign on_cross = (RESULT_BITS'(pos.x) == cur_x) || (RESULT_BITS'(pos.y) == cur_y);

    always_ff @(posedge cclk) begin
        if (point_valid) begin
            held <= point;
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            held_ok <= 1'b0;
            lock_x  <= '0;
            lock_y  <= '0;
        end else begin
            if (point_valid) begin
                held_ok <= 1'b1;
            end
            if (take_lock) begin
                lock_x <= map_x;
                lock_y <= map_y;
            end
        end
    end

    // one pixel of latency, outputs move with the tft_clk rising edge
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            data_ena <= 1'b0;
            rgb      <= RGB_BLACK;
        end else if (pix_stb) begin
            data_ena <= active;
            if (!active) begin
                rgb <= RGB_BLACK;
            end else if (on_cross) begin
                rgb <= RGB_WHITE;
            end else begin
                rgb <= background;
            end
        end
    end

    blank_is_black: assert property (@(posedge cclk) disable iff (!rst_n)
        !data_ena |-> (rgb == RGB_BLACK));

endmodule

// File: rtl/tft_pkg.sv
package tft_pkg;

    localparam int POS_X_W = 10;
    localparam int POS_Y_W = 9;
    localparam int COLOR_W = 8;

    // raster position, x counts pixels and y counts lines
    typedef struct packed {
        logic [POS_X_W-1:0] x;
        logic [POS_Y_W-1:0] y;
    } pixel_pos_t;

    // same bit order as the 24-bit background input
    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } rgb_t;

    localparam rgb_t RGB_BLACK = '{red: 8'h00, green: 8'h00, blue: 8'h00};
    localparam rgb_t RGB_WHITE = '{red: 8'hff, green: 8'hff, blue: 8'hff};

    // panel control levels
    typedef struct packed {
        logic vdd;
        logic display;
        logic backlight;
    } tft_ctrl_t;

endpackage

// File: rtl/tft_timing.sv
`timescale 1ns/1ns

module tft_timing import tft_pkg::*; #(
    parameter int H_ACTIVE    = 480,
    parameter int H_TOTAL     = 525,
    parameter int V_ACTIVE    = 272,
    parameter int V_TOTAL     = 286,
    parameter int PIXEL_DIV   = 4,
    parameter int POWER_DELAY = 1000,
    parameter int PWM_PERIOD  = 256
) (
    input  logic       cclk,
    input  logic       rst_n,
    input  logic [7:0] duty,
    output logic       pix_stb,
    output pixel_pos_t pos,
    output logic       active,
    output logic       new_frame,
    output logic       tft_clk,
    output tft_ctrl_t  ctrl
);

    localparam int PDIV_W = $clog2(PIXEL_DIV + 1);
    localparam int PWR_W  = $clog2(POWER_DELAY + 1);
    localparam int PWM_W  = $clog2(PWM_PERIOD + 1);

    logic [PDIV_W-1:0] pdiv_cnt;
    logic [PWR_W-1:0]  pwr_cnt;
    logic [PWM_W-1:0]  pwm_cnt;
    logic              line_end;

    assign pix_stb   = (pdiv_cnt == PDIV_W'(PIXEL_DIV - 1));
    assign line_end  = (pos.x == POS_X_W'(H_TOTAL - 1));
    assign active    = (pos.x < POS_X_W'(H_ACTIVE)) && (pos.y < POS_Y_W'(V_ACTIVE));
    assign new_frame = pix_stb && (pos.x == '0) && (pos.y == '0);

    always_ff @(posedge cclk) begin
        if (!rst_n || pix_stb) begin
            pdiv_cnt <= '0;
        end else begin
            pdiv_cnt <= pdiv_cnt + 1'b1;
        end
    end

    // high for the first half of each pixel period
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            tft_clk <= 1'b0;
        end else if (pix_stb) begin
            tft_clk <= 1'b1;
        end else if (pdiv_cnt == PDIV_W'(PIXEL_DIV / 2 - 1)) begin
            tft_clk <= 1'b0;
        end
    end

    // raster counters step once per pixel
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (pix_stb) begin
            if (line_end) begin
                pos.x <= '0;
                if (pos.y == POS_Y_W'(V_TOTAL - 1)) begin
                    pos.y <= '0;
                end else begin
                    pos.y <= pos.y + 1'b1;
                end
            end else begin
                pos.x <= pos.x + 1'b1;
            end
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n || pwm_cnt == PWM_W'(PWM_PERIOD - 1)) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // vdd first, display after the delay, then backlight PWM
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            ctrl    <= '0;
            pwr_cnt <= '0;
        end else begin
            ctrl.vdd <= 1'b1;
            if (ctrl.vdd && !ctrl.display) begin
                if (pwr_cnt == PWR_W'(POWER_DELAY - 1)) begin
                    ctrl.display <= 1'b1;
                end else begin
                    pwr_cnt <= pwr_cnt + 1'b1;
                end
            end
            ctrl.backlight <= ctrl.display && (pwm_cnt < duty);
        end
    end

    pos_in_range: assert property (@(posedge cclk) disable iff (!rst_n)
        (pos.x < POS_X_W'(H_TOTAL)) && (pos.y < POS_Y_W'(V_TOTAL)));

endmodule

// File: rtl/tft_touch_top.sv
`timescale 1ns/1ns

module tft_touch_top import touch_pkg::*, tft_pkg::*; #(
    parameter int H_ACTIVE        = 480,
    parameter int H_TOTAL         = 525,
    parameter int V_ACTIVE        = 272,
    parameter int V_TOTAL         = 286,
    parameter int PIXEL_DIV       = 4,
    parameter int POWER_DELAY     = 1000,
    parameter int PWM_PERIOD      = 256,
    parameter int TOUCH_CLK_DIV   = 50,
    parameter int X_OFFSET        = 150,
    parameter int Y_OFFSET        = 300,
    parameter int PRESS_THRESHOLD = 256,
    parameter int SCALE_SHIFT     = 3
) (
    input  logic        cclk,
    input  logic        rst_n,
    input  logic [7:0]  switch,
    input  logic [23:0] background,
    input  logic        touch_busy,
    input  logic        touch_data_out,
    output logic        touch_csb,
    output logic        touch_clk,
    output logic        touch_data_in,
    output logic        tft_clk,
    output logic        tft_data_ena,
    output logic        tft_vdd,
    output logic        tft_display,
    output logic        tft_backlight,
    output logic [7:0]  tft_red,
    output logic [7:0]  tft_green,
    output logic [7:0]  tft_blue
);

    touch_point_t point;
    logic         point_valid;
    pixel_pos_t   pos;
    logic         active;
    logic         pix_stb;
    logic         new_frame;
    rgb_t         rgb;
    tft_ctrl_t    ctrl;

    touchpad_controller #(
        .TOUCH_CLK_DIV(TOUCH_CLK_DIV)
    ) u_touch (
        .cclk        (cclk),
        .rst_n       (rst_n),
        .touch_busy  (touch_busy),
        .data_in     (touch_data_out),
        .touch_clk   (touch_clk),
        .touch_csb   (touch_csb),
        .data_out    (touch_data_in),
        .point       (point),
        .point_valid (point_valid)
    );

    tft_timing #(
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .PIXEL_DIV   (PIXEL_DIV),
        .POWER_DELAY (POWER_DELAY),
        .PWM_PERIOD  (PWM_PERIOD)
    ) u_timing (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .duty      (switch),
        .pix_stb   (pix_stb),
        .pos       (pos),
        .active    (active),
        .new_frame (new_frame),
        .tft_clk   (tft_clk),
        .ctrl      (ctrl)
    );

    cursor_overlay #(
        .X_OFFSET        (X_OFFSET),
        .Y_OFFSET        (Y_OFFSET),
        .PRESS_THRESHOLD (PRESS_THRESHOLD),
        .SCALE_SHIFT     (SCALE_SHIFT)
    ) u_overlay (
        .cclk        (cclk),
        .rst_n       (rst_n),
        .point       (point),
        .point_valid (point_valid),
        .pos         (pos),
        .active      (active),
        .pix_stb     (pix_stb),
        .new_frame   (new_frame),
        .background  (rgb_t'(background)),
        .rgb         (rgb),
        .data_ena    (tft_data_ena)
    );

    // panel pins
    assign tft_red       = rgb.red;
    assign tft_green     = rgb.green;
    assign tft_blue      = rgb.blue;
    assign tft_vdd       = ctrl.vdd;
    assign tft_display   = ctrl.display;
    assign tft_backlight = ctrl.backlight;

endmodule

// File: rtl/touch_pkg.sv
package touch_pkg;

    // converter channel address, bits A2..A0 of the control byte
    typedef enum logic [2:0] {
        CHAN_X = 3'b101,
        CHAN_Y = 3'b001,
        CHAN_Z = 3'b011
    } touch_chan_e;

    // control byte, shifted out msb first
    typedef struct packed {
        logic        start;
        touch_chan_e chan;
        // 0 selects 12-bit conversion
        logic        mode;
        // 0 selects differential reference
        logic        ser_dfr;
        logic [1:0]  pd;
    } touch_cmd_t;

    localparam int CMD_BITS    = 8;
    localparam int RESULT_BITS = 12;
    localparam int PAD_CLOCKS  = 3;
    // csb high time, counted in touch_clk half periods
    localparam int IDLE_HALVES = 4;

    typedef struct packed {
        logic [RESULT_BITS-1:0] x;
        logic [RESULT_BITS-1:0] y;
        logic [RESULT_BITS-1:0] z;
    } touch_point_t;

endpackage

// File: rtl/touchpad_controller.sv
`timescale 1ns/1ns

module touchpad_controller import touch_pkg::*; #(
    parameter int TOUCH_CLK_DIV = 50
) (
    input  logic         cclk,
    input  logic         rst_n,
    input  logic         touch_busy,
    input  logic         data_in,
    output logic         touch_clk,
    output logic         touch_csb,
    output logic         data_out,
    output touch_point_t point,
    output logic         point_valid
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD,
        ST_WAIT,
        ST_READ,
        ST_PAD
    } state_e;

    localparam int DIV_W = $clog2(TOUCH_CLK_DIV + 1);

    state_e                 state;
    logic [DIV_W-1:0]       div_cnt;
    logic                   half_tick;
    logic                   rise;
    logic                   fall;
    logic [3:0]             bit_cnt;
    touch_chan_e            chan;
    touch_cmd_t             cmd;
    logic [CMD_BITS-1:0]    cmd_sr;
    logic [RESULT_BITS-1:0] res_sr;
    logic [RESULT_BITS-1:0] result;
    logic                   last_bit;
    logic                   round_done;
    touch_point_t           acc;

    // 12-bit single conversion, differential reference, no power-down change
    assign cmd = '{start: 1'b1, chan: chan, mode: 1'b0, ser_dfr: 1'b0, pd: 2'b00};

    assign half_tick  = (div_cnt == DIV_W'(TOUCH_CLK_DIV - 1));
    assign rise       = half_tick && !touch_clk && (state != ST_IDLE);
    assign fall       = half_tick && touch_clk;
    assign result     = {res_sr[RESULT_BITS-2:0], data_in};
    assign last_bit   = (state == ST_READ) && rise && (bit_cnt == RESULT_BITS - 1);
    assign round_done = (state == ST_PAD) && fall && (bit_cnt == PAD_CLOCKS);

    // touch_clk half period
    always_ff @(posedge cclk) begin
        if (!rst_n || half_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            touch_csb   <= 1'b1;
            touch_clk   <= 1'b0;
            data_out    <= 1'b0;
            bit_cnt     <= '0;
            chan        <= CHAN_X;
            point_valid <= 1'b0;
        end else begin
            point_valid <= 1'b0;
            if (rise) begin
                touch_clk <= 1'b1;
            end
            // next command bit goes out while the clock is low
            if (fall) begin
                touch_clk <= 1'b0;
                data_out  <= cmd_sr[CMD_BITS-2];
            end
            case (state)
                ST_IDLE: begin
                    if (half_tick) begin
                        if (bit_cnt == IDLE_HALVES - 1) begin
                            bit_cnt   <= '0;
                            touch_csb <= 1'b0;
                            data_out  <= cmd[CMD_BITS-1];
                            state     <= ST_CMD;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_CMD: begin
                    if (rise) begin
                        if (bit_cnt == CMD_BITS - 1) begin
                            bit_cnt <= '0;
                            state   <= ST_WAIT;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_WAIT: begin
                    if (rise && !touch_busy) begin
                        state <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (last_bit) begin
                        bit_cnt <= '0;
                        state   <= ST_PAD;
                    end else if (rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_PAD: begin
                    if (round_done) begin
                        bit_cnt     <= '0;
                        touch_csb   <= 1'b1;
                        state       <= ST_IDLE;
                        point_valid <= (chan == CHAN_Z);
                        case (chan)
                            CHAN_X:  chan <= CHAN_Y;
                            CHAN_Y:  chan <= CHAN_Z;
                            default: chan <= CHAN_X;
                        endcase
                    end else if (rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // shift registers and sample storage
    always_ff @(posedge cclk) begin
        if (state == ST_IDLE && half_tick) begin
            cmd_sr <= cmd;
        end else if (fall) begin
            cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};
        end
        if (state == ST_READ && rise) begin
            res_sr <= result;
        end
        if (last_bit) begin
            case (chan)
                CHAN_X:  acc.x <= result;
                CHAN_Y:  acc.y <= result;
                default: acc.z <= result;
            endcase
        end
        if (round_done && chan == CHAN_Z) begin
            point <= acc;
        end
    end

    csb_high_clk_low: assert property (@(posedge cclk) disable iff (!rst_n)
        touch_csb |-> !touch_clk);

endmodule

// File: verification/tb_tft_touch.sv
`timescale 1ns/1ns

module tb_tft_touch import touch_pkg::*, tft_pkg::*; ();

    localparam int H_ACTIVE        = 32;
    localparam int H_TOTAL         = 40;
    localparam int V_ACTIVE        = 16;
    localparam int V_TOTAL         = 20;
    localparam int PIXEL_DIV       = 2;
    localparam int POWER_DELAY     = 20;
    localparam int PWM_PERIOD      = 256;
    localparam int TOUCH_CLK_DIV   = 2;
    localparam int X_OFFSET        = 150;
    localparam int Y_OFFSET        = 300;
    localparam int PRESS_THRESHOLD = 256;
    localparam int SCALE_SHIFT     = 3;
    localparam int ROWS            = 6;
    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL * PIXEL_DIV;
    localparam int TIMEOUT_CYCLES  = ROWS * 5 * FRAME_CYCLES + 200;
    localparam int STIM_DELAY      = 2;

    typedef struct packed {
        touch_point_t raw;
        logic [7:0]   duty;
    } stim_row_t;

    logic         cclk = 1'b0;
    logic         rst_n;
    logic [7:0]   switch;
    rgb_t         background;
    touch_point_t sample;
    logic         touch_busy, touch_data_out, touch_csb, touch_clk, touch_data_in;
    logic         tft_clk, tft_data_ena, tft_vdd, tft_display, tft_backlight;
    logic [7:0]   tft_red, tft_green, tft_blue;
    int           protocol_errors;

    stim_row_t table_rows [ROWS];
    int        cycle = 0;
    int        col = 0;
    int        line = 0;
    int        low_run = 0;
    int        frames_seen = 0;
    int        exp_x = 0;
    int        exp_y = 0;
    rgb_t      exp_bg;
    rgb_t      want;
    rgb_t      got;
    logic      checking = 1'b0;
    int        rst_cycle = -1;
    int        vdd_cycle = -1;
    int        disp_cycle = -1;
    int        pix_errors = 0;
    int        power_errors = 0;
    int        bl_errors = 0;

    tft_touch_top #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .PIXEL_DIV(PIXEL_DIV), .POWER_DELAY(POWER_DELAY), .PWM_PERIOD(PWM_PERIOD),
        .TOUCH_CLK_DIV(TOUCH_CLK_DIV), .X_OFFSET(X_OFFSET), .Y_OFFSET(Y_OFFSET),
        .PRESS_THRESHOLD(PRESS_THRESHOLD), .SCALE_SHIFT(SCALE_SHIFT)
    ) UUT (
        .cclk(cclk), .rst_n(rst_n), .switch(switch), .background(background),
        .touch_busy(touch_busy), .touch_data_out(touch_data_out), .touch_csb(touch_csb),
        .touch_clk(touch_clk), .touch_data_in(touch_data_in), .tft_clk(tft_clk),
        .tft_data_ena(tft_data_ena), .tft_vdd(tft_vdd), .tft_display(tft_display),
        .tft_backlight(tft_backlight), .tft_red(tft_red), .tft_green(tft_green),
        .tft_blue(tft_blue)
    );

    touch_panel_model u_panel (
        .touch_csb(touch_csb), .touch_clk(touch_clk), .touch_data_in(touch_data_in),
        .sample(sample), .touch_busy(touch_busy), .touch_data_out(touch_data_out),
        .protocol_errors(protocol_errors)
    );

    always #20 cclk = ~cclk;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // offset removed modulo 4096, then scaled down
    function automatic int map_axis(input int raw, input int offset);
        return ((raw - offset) & 4095) >> SCALE_SHIFT;
    endfunction

    task automatic print_error_counts();
        $display("errors: raster and pixel %0d, power %0d, backlight %0d, protocol %0d",
                 pix_errors, power_errors, bl_errors, protocol_errors);
    endtask

    task automatic count_backlight(input int duty_want);
        int highs;
        highs = 0;
        repeat (PWM_PERIOD) begin
            @(negedge cclk);
            if (tft_backlight === 1'b1) begin
                highs++;
            end
        end
        if (highs != duty_want) begin
            bl_errors++;
            $display("Fail %0t ns: tft_backlight high cycles expected %0d, got %0d",
                     $time, duty_want, highs);
        end
    endtask

    always @(posedge cclk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_error_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    // power sequence and reset levels
    always @(negedge cclk) begin
        if (!rst_n) begin
            if (cycle > 0 && (tft_data_ena !== 1'b0 || tft_vdd !== 1'b0)) begin
                power_errors++;
                $display("Fail %0t ns: tft_data_ena/tft_vdd in reset expected 0/0, got %b/%b",
                         $time, tft_data_ena, tft_vdd);
            end
        end else begin
            if (rst_cycle < 0) begin
                rst_cycle = cycle;
            end
            if (tft_vdd === 1'b1 && vdd_cycle < 0) begin
                vdd_cycle = cycle;
            end
            if (tft_display === 1'b1 && disp_cycle < 0) begin
                disp_cycle = cycle;
                if (disp_cycle - vdd_cycle < POWER_DELAY - 2 ||
                    disp_cycle - vdd_cycle > POWER_DELAY + 2) begin
                    power_errors++;
                    $display("Fail %0t ns: tft_display delay expected %0d, got %0d cycles",
                             $time, POWER_DELAY, disp_cycle - vdd_cycle);
                end
            end
            if (cycle == rst_cycle + 3 && vdd_cycle < 0) begin
                power_errors++;
                $display("tft_vdd did not rise within two cycles of reset release");
            end
            if (cycle == rst_cycle + POWER_DELAY + 6 && disp_cycle < 0) begin
                power_errors++;
                $display("tft_display never rose after tft_vdd");
            end
            if (tft_backlight === 1'b1 && tft_display !== 1'b1) begin
                power_errors++;
                $display("Fail %0t ns: tft_backlight before tft_display expected 0, got 1", $time);
            end
        end
    end

    // one sample per pixel while tft_clk is low and the outputs are steady
    always @(negedge tft_clk) begin
        if (rst_n) begin
            if (tft_data_ena === 1'b1) begin
                if (checking) begin
                    want = (col == exp_x || line == exp_y) ? rgb_t'(24'hffffff) : exp_bg;
                    got  = {tft_red, tft_green, tft_blue};
                    if (got !== want) begin
                        pix_errors++;
                        $display("Fail %0t ns: tft rgb at (%0d,%0d) expected %h, got %h",
                                 $time, col, line, want, got);
                    end
                end
                col++;
                low_run = 0;
            end else begin
                if (col != 0) begin
                    if (col != H_ACTIVE) begin
                        pix_errors++;
                        $display("Fail %0t ns: tft_data_ena samples in line %0d expected %0d, got %0d",
                                 $time, line, H_ACTIVE, col);
                    end
                    line++;
                    col = 0;
                end
                low_run++;
                // longer than a line blank, so the frame is over
                if (low_run == H_TOTAL - H_ACTIVE + 1) begin
                    if (line != V_ACTIVE) begin
                        pix_errors++;
                        $display("Fail %0t ns: active lines in frame %0d expected %0d, got %0d",
                                 $time, frames_seen, V_ACTIVE, line);
                    end
                    line = 0;
                    frames_seen++;
                end
            end
        end
    end

    initial begin
        logic [31:0] seed;
        int          target;
        // raw x, raw y, raw z, switch duty
        table_rows[0] = {12'd190, 12'd324, 12'd900, 8'd64};
        table_rows[1] = {12'd400, 12'd420, 12'd300, 8'd200};
        table_rows[2] = {12'd161, 12'd305, 12'd256, 8'd0};
        table_rows[3] = {12'd300, 12'd380, 12'd100, 8'd255};
        table_rows[4] = {12'd250, 12'd360, 12'd2000, 8'd128};
        table_rows[5] = {12'd1000, 12'd1000, 12'd255, 8'd1};
        seed       = 32'd62;
        rst_n      = 1'b0;
        switch     = 8'd0;
        background = '0;
        sample     = '0;
        repeat (4) @(posedge cclk);
        #STIM_DELAY;
        rst_n = 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            seed = next_random(seed);
            @(posedge cclk);
            #STIM_DELAY;
            sample     = table_rows[r].raw;
            switch     = table_rows[r].duty;
            background = rgb_t'(seed[31:8]);
            exp_bg     = rgb_t'(seed[31:8]);
            // below the threshold the old lock stays
            if (table_rows[r].raw.z >= PRESS_THRESHOLD) begin
                exp_x = map_axis(table_rows[r].raw.x, X_OFFSET);
                exp_y = map_axis(table_rows[r].raw.y, Y_OFFSET);
            end
            target = frames_seen + 3;
            wait (frames_seen == target);
            checking = 1'b1;
            count_backlight(table_rows[r].duty);
            wait (frames_seen == target + 1);
            checking = 1'b0;
        end
        print_error_counts();
        if (pix_errors + power_errors + bl_errors + protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verification/touch_panel_model.sv
`timescale 1ns/1ns

module touch_panel_model import touch_pkg::*; (
    input  logic         touch_csb,
    input  logic         touch_clk,
    input  logic         touch_data_in,
    input  touch_point_t sample,
    output logic         touch_busy,
    output logic         touch_data_out,
    output int           protocol_errors
);

    // rising touch_clk edges since csb fell
    int                     clk_n = 0;
    int                     errs = 0;
    logic [CMD_BITS-1:0]    cmd_bits = '0;
    touch_cmd_t             cmd;
    touch_chan_e            expect_chan = CHAN_X;
    logic [RESULT_BITS-1:0] answer = '0;
    logic                   data_q = 1'b0;

    // busy from the last command clock until the falling edge of the next one
    assign touch_busy      = (clk_n == CMD_BITS) || (clk_n == CMD_BITS + 1 && touch_clk);
    assign touch_data_out  = data_q;
    assign protocol_errors = errs;

    always @(posedge touch_clk or posedge touch_csb) begin
        if (touch_csb) begin
            clk_n = 0;
        end else begin
            clk_n = clk_n + 1;
            if (clk_n <= CMD_BITS) begin
                cmd_bits = {cmd_bits[CMD_BITS-2:0], touch_data_in};
            end
            if (clk_n == CMD_BITS) begin
                cmd = touch_cmd_t'(cmd_bits);
                if (!cmd.start) begin
                    errs = errs + 1;
                    $display("touch model: command 0x%h at %0t ns has no start bit", cmd_bits, $time);
                end
                if (cmd.chan != expect_chan) begin
                    errs = errs + 1;
                    $display("touch model: channel %b at %0t ns breaks the X, Y, Z order",
                             cmd.chan, $time);
                end
                case (expect_chan)
                    CHAN_X:  expect_chan = CHAN_Y;
                    CHAN_Y:  expect_chan = CHAN_Z;
                    default: expect_chan = CHAN_X;
                endcase
                case (cmd.chan)
                    CHAN_X:  answer = sample.x;
                    CHAN_Y:  answer = sample.y;
                    default: answer = sample.z;
                endcase
            end
        end
    end

    // result bits change while touch_clk is low, msb first
    always @(negedge touch_clk) begin
        if (!touch_csb && clk_n >= CMD_BITS + 2 && clk_n < CMD_BITS + 2 + RESULT_BITS) begin
            data_q = answer[CMD_BITS + 1 + RESULT_BITS - clk_n];
        end else begin
            data_q = 1'b0;
        end
    end

endmodule
